//--- project.f
logic/qa7_pkg.sv
logic/qa7_timebase.sv
logic/qa7_toggle.sv
logic/qa7_tty_fifo.sv
logic/qa7_uart_tx.sv
logic/qa7_seg_scan.sv
logic/qa7_top.sv
tb/qa7_top_properties.sv
tb/tb_qa7_top.sv

//--- Makefile
# Verilator simulation of the qa7 front panel

TOP       ?= tb_qa7_top
LOG       ?= sim.log
VERILATOR ?= verilator
SEED      ?= 49276
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0

.PHONY: sim clean

# a crashed or aborted run is logged as a failure too
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) --Mdir $(OBJ_DIR) -f project.f
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "TEST FAILED" >> $(LOG)
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb/tb_qa7_top.sv
// qa7 top testbench
`timescale 1ns/1ns

module tb_qa7_top #(parameter int SEED = 32'hc07c);

localparam int N_STIM = 6;
localparam int BURST_LEN = 24;               // more than the FIFO holds
localparam int PRESS_NS = 6_000_000;         // 3 ms held, 3 ms released

// stimulus table, byte unused on burst rows
localparam logic [7:0] stim_byte [N_STIM] = '{8'h55, 8'ha3, 8'h00, 8'hff, 8'h00, 8'h3c};
localparam logic stim_burst [N_STIM] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
localparam logic exp_busy [N_STIM] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};

logic sys_clk_p;
logic rst;
logic [2:1] button;
logic tty_stb;
logic [7:0] tty_dat;
logic tty_busy;
logic uart_txd;
logic [5:0] led;
logic [7:0] hex;
logic [2:0] hsel;
logic [1:0] gpio;

int errors = 0;
int tx_count = 0;                            // bytes handed to the DUT
int rx_count = 0;                            // bytes decoded off uart_txd
int us_pulses = 0;
int ms_pulses = 0;
integer seed;
logic busy_seen;                             // producer had to stall
logic [7:0] last_sent;
logic [1:0] flag_exp = 2'b00;                // expected toggle flags
logic [7:0] exp_q [$];                       // bytes still in flight

qa7_top u_qa7_top
(
   .sys_clk_p(sys_clk_p),
   .rst(rst),
   .button(button),
   .tty_stb(tty_stb),
   .tty_dat(tty_dat),
   .tty_busy(tty_busy),
   .uart_txd(uart_txd),
   .led(led),
   .hex(hex),
   .hsel(hsel),
   .gpio(gpio)
);

initial
begin
   sys_clk_p = 1'b0;
   forever
      #5 sys_clk_p = ~sys_clk_p;             // 100 MHz sim clock, 10 ns
end

task automatic report_value(input string name, input logic [31:0] got, input logic [31:0] want);
   errors++;
   $display("FAILED at %0t ns: %s = %0h, expected %0h", $time, name, got, want);
endtask

task automatic report_issue(input string what);
   errors++;
   $display("ERROR at %0t ns: %s", $time, what);
endtask

task automatic next_cycle;                   // 1 ns past the next rising edge
   @(posedge sys_clk_p);
   #1;
endtask

task automatic send_byte(input logic [7:0] b);
   while (tty_busy !== 1'b0)
   begin
      busy_seen = 1'b1;                      // wait out back-pressure
      if (led[3] !== 1'b1)
         report_value("led[3]", 32'(led[3]), 32'd1);
      next_cycle();
   end
   tty_stb = 1'b1;
   tty_dat = b;
   exp_q.push_back(b);
   last_sent = b;
   tx_count++;
   next_cycle();
   tty_stb = 1'b0;
   if (led[2] !== 1'b1)                      // byte now held in the FIFO
      report_value("led[2]", 32'(led[2]), 32'd1);
endtask

task automatic press_button(input int idx);
   int flips;
   logic prev;
   flips = 0;
   next_cycle();                             // line up with the drive edge
   prev = led[idx-1];
   flag_exp[idx-1] = ~flag_exp[idx-1];       // one flip per press
   button[idx] = 1'b0;
   for (int t = 0; t < PRESS_NS / 10; t++)
   begin
      if (t == PRESS_NS / 20)
         button[idx] = 1'b1;                 // release re-arms
      next_cycle();
      if (led[idx-1] !== prev)
         flips++;
      prev = led[idx-1];
   end
   if (flips != 1)
      report_issue($sformatf("led[%0d] flipped %0d times in one press", idx - 1, flips));
   if (led[idx-1] !== flag_exp[idx-1])
      report_value($sformatf("led[%0d]", idx - 1), 32'(led[idx-1]), 32'(flag_exp[idx-1]));
endtask

task automatic check_display;
   logic [7:0] want;
   logic [2:0] seen;
   int blanks;
   blanks = 0;
   seen = 3'b000;
   repeat (6)                                // one full scan, 5 down to 0
   begin
      do
         @(negedge sys_clk_p);
      while (gpio[1] !== 1'b1);
      @(negedge sys_clk_p);                  // select has moved
      want = ~qa7_pkg::SEG_BLANK;
      case (hsel)
         3'b110: want = ~qa7_pkg::seg_font[last_sent[3:0]];
         3'b101: want = ~qa7_pkg::seg_font[last_sent[7:4]];
         3'b011: want = ~qa7_pkg::seg_font[4'(tx_count)];   // count mod 16
         3'b111: blanks++;
         default: report_issue("hsel selects more than one digit");
      endcase
      seen = seen | ~hsel;                   // digit positions visited
      if (hex !== want)
         report_value("hex", 32'(hex), 32'(want));
   end
   if (blanks != 3 || seen !== 3'b111)
      report_issue("scan did not pass each digit and three blank positions");
endtask

task automatic finish_run;
   $display("bytes sent %0d, bytes received %0d, errors %0d", tx_count, rx_count, errors);
   if (errors == 0)
      $display("TEST OK");
   else
      $display("TEST FAILED");
   $finish;
endtask

// serial decoder, samples at bit centres
initial
begin : uart_decoder
   logic [7:0] rx;
   logic [7:0] want;
   wait (rst === 1'b0);
   forever
   begin
      @(negedge uart_txd);
      repeat (qa7_pkg::UART_DIV / 2)
         @(negedge sys_clk_p);
      if (uart_txd !== 1'b0)
         report_issue("start bit on uart_txd shorter than half a bit");
      for (int i = 0; i < 8; i++)
      begin
         repeat (qa7_pkg::UART_DIV)
            @(negedge sys_clk_p);
         rx[i] = uart_txd;                   // lsb first
      end
      repeat (qa7_pkg::UART_DIV)
         @(negedge sys_clk_p);
      if (uart_txd !== 1'b1)
         report_issue("stop bit missing on uart_txd");
      if (exp_q.size() == 0)
         report_issue("uart_txd sent a byte that was never written");
      else
      begin
         want = exp_q.pop_front();
         if (rx !== want)
            report_value("uart_txd byte", 32'(rx), 32'(want));
      end
      rx_count++;
   end
end

// gpio strobe spacing
initial
begin : strobe_monitor
   int gap;
   logic ms_want;
   gap = 0;
   forever
   begin
      @(negedge sys_clk_p);
      if (rst !== 1'b0)
         gap = 0;
      else
      begin
         if (gpio[0] === 1'b1)
         begin
            us_pulses++;
            if (us_pulses > 1 && gap != qa7_pkg::US_DIV)
               report_value("gpio[0] period", 32'(gap), qa7_pkg::US_DIV);
            gap = 1;
         end
         else
            gap++;
         ms_want = (gpio[0] === 1'b1) && (us_pulses % qa7_pkg::MS_DIV == 0);
         if (gpio[1] !== ms_want)
            report_value("gpio[1]", 32'(gpio[1]), 32'(ms_want));
         if (gpio[1] === 1'b1)
            ms_pulses++;
      end
   end
end

initial
begin : watchdog
   longint limit_ns;
   int n_bytes;
   n_bytes = 0;
   for (int i = 0; i < N_STIM; i++)
      n_bytes += stim_burst[i] ? BURST_LEN : 1;
   // frames on the line, four presses, then margin
   limit_ns = longint'(n_bytes) * 10 * qa7_pkg::UART_DIV * 10 + 4 * PRESS_NS + 20_000_000;
   #(limit_ns);
   report_issue("watchdog expired before the tests finished");
   finish_run();
end

initial
begin : main_seq
   seed = SEED;
   rst = 1'b1;
   button = 2'b11;                           // released
   tty_stb = 1'b0;
   tty_dat = 8'h00;
   busy_seen = 1'b0;
   last_sent = 8'h00;
   repeat (8)
      @(posedge sys_clk_p);
   #1;
   rst = 1'b0;
   if (uart_txd !== 1'b1)
      report_value("uart_txd", 32'(uart_txd), 32'd1);
   if (tty_busy !== 1'b0)
      report_value("tty_busy", 32'(tty_busy), 32'd0);
   if (led[1:0] !== 2'b00)
      report_value("led[1:0]", 32'(led[1:0]), 32'd0);
   if (hsel !== 3'b110)                      // position 0 selected
      report_value("hsel", 32'(hsel), 32'b110);
   for (int i = 0; i < N_STIM; i++)
   begin
      busy_seen = 1'b0;
      if (stim_burst[i])
         for (int k = 0; k < BURST_LEN; k++)
            send_byte(8'($random(seed)));
      else
         send_byte(stim_byte[i]);
      while (rx_count != tx_count)
         next_cycle();
      if (busy_seen !== exp_busy[i])
         report_value($sformatf("tty_busy seen, row %0d", i), 32'(busy_seen), 32'(exp_busy[i]));
   end
   repeat (qa7_pkg::UART_DIV)
      next_cycle();                          // rest of the last stop bit
   if (led[3:2] !== 2'b00)                   // drained and not busy
      report_value("led[3:2]", 32'(led[3:2]), 32'd0);
   if (led[5:4] !== 2'(tx_count))
      report_value("led[5:4]", 32'(led[5:4]), 32'(2'(tx_count)));
   check_display();
   press_button(1);
   press_button(1);
   press_button(2);
   press_button(2);
   if (led[1:0] !== 2'b00)                   // two presses each, back to 0
      report_value("led[1:0]", 32'(led[1:0]), 32'd0);
   if (ms_pulses == 0)
      report_issue("no ms strobe seen on gpio[1]");
   finish_run();
end

endmodule

//--- tb/qa7_top_properties.sv
// qa7 top protocol checks
`timescale 1ns/1ns

module qa7_top_properties
(
   input logic       sys_clk_p,     // system clock
   input logic       rst,           // sync reset
   input logic       tty_stb,       // core byte strobe
   input logic       tty_busy,      // FIFO full
   input logic       uart_txd,      // serial line
   input logic [2:0] hsel,          // digit select, active low
   input logic [1:0] gpio           // us and ms strobes
);

// core must hold off while the buffer is full
a_stb_during_busy: assert property (@(posedge sys_clk_p) disable iff (rst)
   tty_stb |-> !tty_busy)
   else $error("tty_stb raised while tty_busy was high");

a_ms_without_us: assert property (@(posedge sys_clk_p) disable iff (rst)
   gpio[1] |-> gpio[0])          // ms strobe rides on a us strobe
   else $error("ms strobe without us strobe on gpio");

// positions 3..5 have no digit, so all high is legal there
a_hsel_onehot: assert property (@(posedge sys_clk_p) disable iff (rst)
   $onehot0(~hsel))
   else $error("more than one digit selected on hsel");

a_txd_idle_in_reset: assert property (@(posedge sys_clk_p)
   rst |=> uart_txd)             // line idles high once reset is seen
   else $error("uart_txd not high during reset");

endmodule

bind qa7_top qa7_top_properties u_qa7_top_properties
(
   .sys_clk_p(sys_clk_p),
   .rst(rst),
   .tty_stb(tty_stb),
   .tty_busy(tty_busy),
   .uart_txd(uart_txd),
   .hsel(hsel),
   .gpio(gpio)
);

//--- logic/qa7_top.sv
// qa7 front panel and debug console
`timescale 1ns/1ns

module qa7_top
(
   input  logic       sys_clk_p,     // 50 MHz system clock
   input  logic       rst,           // sync reset, active high
                                     //
   input  logic [2:1] button,        // push buttons, low when pressed
                                     //
   input  logic       tty_stb,       // debug byte strobe from core
   input  logic [7:0] tty_dat,       // debug byte value
   output logic       tty_busy,      // core must hold off strobes
                                     //
   output logic       uart_txd,      // console serial out
   output logic [5:0] led,           // status leds
   output logic [7:0] hex,           // segment drive, active low
   output logic [2:0] hsel,          // digit select, active low
   output logic [1:0] gpio           // us and ms strobes for the scope
);

logic ena_us;                        // microsecond strobe
logic ena_ms;                        // millisecond strobe
logic ena_timer;                     // button 1 flag
logic ena_slow;                      // button 2 flag
                                     //
logic fifo_pop;                      // uart takes a byte
logic fifo_empty;
logic [7:0] fifo_dat;                // head of buffer
                                     //
logic [7:0] last_byte;               // last byte fully sent
logic [3:0] sent_cnt;                // bytes sent mod 16

qa7_timebase u_timebase
(
   .sys_clk_p(sys_clk_p),
   .rst(rst),
   .ena_us(ena_us),
   .ena_ms(ena_ms)
);

qa7_toggle u_tog_timer
(
   .sys_clk_p(sys_clk_p),
   .rst(rst),
   .but_n(button[1]),
   .ena_ms(ena_ms),
   .flag(ena_timer)
);

qa7_toggle u_tog_slow
(
   .sys_clk_p(sys_clk_p),
   .rst(rst),
   .but_n(button[2]),
   .ena_ms(ena_ms),
   .flag(ena_slow)
);

qa7_tty_fifo u_tty_fifo
(
   .sys_clk_p(sys_clk_p),
   .rst(rst),
   .wr_en(tty_stb),
   .wr_dat(tty_dat),
   .full(tty_busy),                  // full stalls the core
   .rd_en(fifo_pop),
   .rd_dat(fifo_dat),
   .empty(fifo_empty)
);

qa7_uart_tx u_uart_tx
(
   .sys_clk_p(sys_clk_p),
   .rst(rst),
   .fifo_empty(fifo_empty),
   .fifo_dat(fifo_dat),
   .fifo_pop(fifo_pop),
   .txd(uart_txd),
   .last_byte(last_byte),
   .sent_cnt(sent_cnt)
);

qa7_seg_scan u_seg_scan
(
   .sys_clk_p(sys_clk_p),
   .rst(rst),
   .ena_ms(ena_ms),
   .last_byte(last_byte),
   .sent_cnt(sent_cnt),
   .hex(hex),
   .hsel(hsel)
);

// status leds
assign led[0] = ena_timer;
assign led[1] = ena_slow;
assign led[2] = ~fifo_empty;         // bytes waiting
assign led[3] = tty_busy;
assign led[5:4] = sent_cnt[1:0];

assign gpio[0] = ena_us;
assign gpio[1] = ena_ms;

endmodule

//--- logic/qa7_seg_scan.sv
// seven-segment display scanner
`timescale 1ns/1ns

module qa7_seg_scan
(
   input  logic       sys_clk_p,     // system clock
   input  logic       rst,           // sync reset
   input  logic       ena_ms,        // scan step strobe
   input  logic [7:0] last_byte,     // shown on positions 0 and 1
   input  logic [3:0] sent_cnt,      // shown on position 2
   output logic [7:0] hex,           // segment drive, active low
   output logic [2:0] hsel           // digit select, active low
);

logic [2:0] sel;                     // current position 0..5
logic [7:0] seg_pat;                 // active-high pattern

// position counter, counts down and wraps
always_ff @(posedge sys_clk_p)
begin
   if (rst)
      sel <= 3'd0;
   else if (ena_ms)
   begin
      if (sel == 3'd0)
         sel <= qa7_pkg::SCAN_LAST;
      else
         sel <= sel - 1'b1;
   end
end

// digit contents
always_comb
begin
   case (sel)
      3'd0:
         seg_pat = qa7_pkg::seg_font[last_byte[3:0]];    // low nibble
      3'd1:
         seg_pat = qa7_pkg::seg_font[last_byte[7:4]];    // high nibble
      3'd2:
         seg_pat = qa7_pkg::seg_font[sent_cnt];
      default:
         seg_pat = qa7_pkg::SEG_BLANK;                   // unused positions
   endcase
end

// board drives segments and digits low
assign hex = ~seg_pat;

assign hsel[0] = (sel != 3'd0);
assign hsel[1] = (sel != 3'd1);
assign hsel[2] = (sel != 3'd2);     // positions 3..5 have no digit

endmodule

//--- logic/qa7_uart_tx.sv
// 8N1 serial transmitter
`timescale 1ns/1ns

module qa7_uart_tx
(
   input  logic       sys_clk_p,     // system clock
   input  logic       rst,           // sync reset
   input  logic       fifo_empty,    // nothing to send
   input  logic [7:0] fifo_dat,      // head byte of the FIFO
   output logic       fifo_pop,      // take head byte
   output logic       txd,           // serial line, idles high
   output logic [7:0] last_byte,     // most recent byte fully sent
   output logic [3:0] sent_cnt       // bytes sent, wraps at 16
);

logic busy;                                  // frame in progress
logic [3:0] bit_cnt;                         // 0 start, 1..8 data, 9 stop
logic [qa7_pkg::UART_W-1:0] div_cnt;         // clocks within bit
logic [8:0] shreg;                           // data bits then stop bit
logic [7:0] cur_byte;                        // byte on the line
logic bit_end;

assign fifo_pop = ~busy & ~fifo_empty;       // idle and work waiting
assign bit_end = (div_cnt == qa7_pkg::UART_LAST);

// frame payload
always_ff @(posedge sys_clk_p)
begin
   if (fifo_pop)
   begin
      cur_byte <= fifo_dat;
      shreg <= {1'b1, fifo_dat};             // lsb first, stop on top
   end
   else if (busy & bit_end)
      shreg <= {1'b1, shreg[8:1]};
end

// bit timing and line control
always_ff @(posedge sys_clk_p)
begin
   if (rst)
   begin
      busy <= 1'b0;
      bit_cnt <= '0;
      div_cnt <= '0;
      txd <= 1'b1;
      last_byte <= 8'h00;
      sent_cnt <= 4'h0;
   end
   else if (fifo_pop)
   begin
      busy <= 1'b1;
      bit_cnt <= '0;
      div_cnt <= '0;
      txd <= 1'b0;                           // start bit next cycle
   end
   else if (busy)
   begin
      if (bit_end)
      begin
         div_cnt <= '0;
         if (bit_cnt == 4'd9)
         begin
            busy <= 1'b0;                    // stop bit done
            last_byte <= cur_byte;
            sent_cnt <= sent_cnt + 1'b1;
         end
         else
         begin
            txd <= shreg[0];
            bit_cnt <= bit_cnt + 1'b1;
         end
      end
      else
         div_cnt <= div_cnt + 1'b1;
   end
end

endmodule

//--- logic/qa7_tty_fifo.sv
// debug byte FIFO
`timescale 1ns/1ns

module qa7_tty_fifo
(
   input  logic       sys_clk_p,     // system clock
   input  logic       rst,           // sync reset
   input  logic       wr_en,         // write strobe from core
   input  logic [7:0] wr_dat,        // byte to store
   output logic       full,          // no room left
   input  logic       rd_en,         // pop head entry
   output logic [7:0] rd_dat,        // head entry, valid while not empty
   output logic       empty          // nothing stored
);

logic [7:0] mem [qa7_pkg::FIFO_DEPTH];     // byte storage
logic [qa7_pkg::FIFO_AW-1:0] wr_ptr;       // next free slot
logic [qa7_pkg::FIFO_AW-1:0] rd_ptr;       // head slot
logic [qa7_pkg::FIFO_AW:0] count;          // occupancy, 0..depth
logic do_wr;
logic do_rd;

assign do_wr = wr_en & ~full;      // writes into a full buffer are dropped
assign do_rd = rd_en & ~empty;

assign full = count[qa7_pkg::FIFO_AW];     // msb set only at depth
assign empty = (count == '0);
assign rd_dat = mem[rd_ptr];               // show-ahead read

// storage
always_ff @(posedge sys_clk_p)
begin
   if (do_wr)
      mem[wr_ptr] <= wr_dat;
end

// pointers and fill level
always_ff @(posedge sys_clk_p)
begin
   if (rst)
   begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
   end
   else
   begin
      if (do_wr)
         wr_ptr <= wr_ptr + 1'b1;    // wraps at depth
      if (do_rd)
         rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
         2'b10:
            count <= count + 1'b1;
         2'b01:
            count <= count - 1'b1;
         default:
            count <= count;          // idle or simultaneous push and pop
      endcase
   end
end

endmodule

//--- logic/qa7_toggle.sv
// debounced push-button toggle
`timescale 1ns/1ns

module qa7_toggle
(
   input  logic sys_clk_p,     // system clock
   input  logic rst,           // sync reset
   input  logic but_n,         // raw button, low when pressed
   input  logic ena_ms,        // sample strobe
   output logic flag           // flips once per press
);

logic [1:0] but_sync;                        // metastability stages
logic [qa7_pkg::DEB_W-1:0] deb_cnt;          // consecutive low samples
logic armed;                                 // cleared until release

always_ff @(posedge sys_clk_p)
begin
   if (rst)
   begin
      but_sync <= 2'b11;                     // released
      deb_cnt <= '0;
      armed <= 1'b1;
      flag <= 1'b0;
   end
   else
   begin
      but_sync <= {but_sync[0], but_n};
      if (ena_ms)
      begin
         if (but_sync[1])
         begin
            deb_cnt <= '0;                   // release re-arms
            armed <= 1'b1;
         end
         else if (deb_cnt == qa7_pkg::DEB_LAST)
         begin
            if (armed)
               flag <= ~flag;                // qualified press
            armed <= 1'b0;
         end
         else
            deb_cnt <= deb_cnt + 1'b1;
      end
   end
end

endmodule

//--- logic/qa7_timebase.sv
// microsecond and millisecond strobes
`timescale 1ns/1ns

module qa7_timebase
(
   input  logic sys_clk_p,     // system clock
   input  logic rst,           // sync reset
   output logic ena_us,        // one clock every microsecond
   output logic ena_ms         // one clock every millisecond
);

logic [qa7_pkg::US_W-1:0] us_cnt;   // clocks within current us
logic [qa7_pkg::MS_W-1:0] ms_cnt;   // us strobes within current ms
logic us_wrap;
logic ms_wrap;

assign us_wrap = (us_cnt == qa7_pkg::US_LAST);
assign ms_wrap = (ms_cnt == qa7_pkg::MS_LAST);

always_ff @(posedge sys_clk_p)
begin
   if (rst)
   begin
      us_cnt <= '0;
      ms_cnt <= '0;
      ena_us <= 1'b0;
      ena_ms <= 1'b0;
   end
   else
   begin
      ena_us <= us_wrap;               // first one 50 clocks out of reset
      ena_ms <= us_wrap & ms_wrap;     // lines up with every 1000th us
      if (us_wrap)
      begin
         us_cnt <= '0;
         if (ms_wrap)
            ms_cnt <= '0;
         else
            ms_cnt <= ms_cnt + 1'b1;   // ms counter only moves on us
      end
      else
         us_cnt <= us_cnt + 1'b1;
   end
end

endmodule

//--- logic/qa7_pkg.sv
// qa7 board shared constants
package qa7_pkg;

   // timebase, 50 MHz system clock
   localparam logic [31:0] US_DIV = 32'd50;         // clocks per microsecond
   localparam int MS_DIV = 1000;                     // us strobes per millisecond
   localparam int US_W = $clog2(US_DIV);
   localparam int MS_W = $clog2(MS_DIV);
   localparam logic [US_W-1:0] US_LAST = US_W'(US_DIV - 32'd1);
   localparam logic [MS_W-1:0] MS_LAST = MS_W'(MS_DIV - 1);

   // serial console, 115200 baud at 50 MHz
   localparam int UART_DIV = 434;                    // clocks per bit
   localparam int UART_W = $clog2(UART_DIV);
   localparam logic [UART_W-1:0] UART_LAST = UART_W'(UART_DIV - 1);

   // debug byte buffer
   localparam int FIFO_DEPTH = 16;
   localparam int FIFO_AW = 4;                       // log2 of depth

   // button filter, in ms samples
   localparam int DEB_TICKS = 2;
   localparam int DEB_W = $clog2(DEB_TICKS + 1);
   localparam logic [DEB_W-1:0] DEB_LAST = DEB_W'(DEB_TICKS - 1);

   // display scan runs 5 down to 0
   localparam logic [2:0] SCAN_LAST = 3'd5;

   // hex font, bit 0 is segment a, bit 7 the dot
   localparam logic [7:0] seg_font [16] = '{
      8'h3f, 8'h06, 8'h5b, 8'h4f,                    // 0 1 2 3
      8'h66, 8'h6d, 8'h7d, 8'h07,                    // 4 5 6 7
      8'h7f, 8'h6f, 8'h77, 8'h7c,                    // 8 9 A b
      8'h39, 8'h5e, 8'h79, 8'h71                     // C d E F
   };
   localparam logic [7:0] SEG_BLANK = 8'h00;         // all segments dark

endpackage
